/* mipsPkg.sv */
package mipsPkg;

        // Primary opcodes in bits 31:26 of the instruction word
        localparam logic [5:0] opRType = 6'h00;
        localparam logic [5:0] opJ     = 6'h02;
        localparam logic [5:0] opJal   = 6'h03;
        localparam logic [5:0] opBne   = 6'h05;
        localparam logic [5:0] opXori  = 6'h0e;
        localparam logic [5:0] opLw    = 6'h23;
        localparam logic [5:0] opSw    = 6'h2b;

        // Function field codes under the R-type opcode
        localparam logic [5:0] functJr  = 6'h08;
        localparam logic [5:0] functAdd = 6'h20;
        localparam logic [5:0] functSub = 6'h22;
        localparam logic [5:0] functSlt = 6'h2a;

        // Link register used by jal
        localparam logic [4:0] linkReg = 5'd31;

        // ALU operation select
        typedef enum logic [2:0] {
                aluAdd = 3'd0,
                aluSub = 3'd1,
                aluXor = 3'd2,
                aluSlt = 3'd3
        } aluOpT;

        // One fetched instruction and its address
        typedef struct packed {
                logic [31:0] pc;
                logic [31:0] word;
        } instrT;

        // Control bits produced by the decoder
        typedef struct packed {
                logic  regWrite;
                logic  memToReg;
                logic  memWrite;
                logic  aluSrc;
                logic  regDst;
                // bne only
                logic  branch;
                // j and jal
                logic  jump;
                // jr
                logic  jumpReg;
                // jal writes the return address
                logic  link;
                aluOpT aluOp;
        } ctrlT;

        // Decoder output with register numbers not yet read
        typedef struct packed {
                ctrlT        ctrl;
                logic [31:0] pc;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [4:0]  dst;
                logic [31:0] imm;
                logic [25:0] jumpIndex;
        } decodedT;

        // Operand stage output with operand values in place of register numbers
        typedef struct packed {
                ctrlT        ctrl;
                logic [31:0] pc;
                logic [4:0]  dst;
                logic [31:0] imm;
                logic [25:0] jumpIndex;
                logic [31:0] opA;
                logic [31:0] opB;
        } issuedT;

        // Register file write
        typedef struct packed {
                logic [4:0]  regNum;
                logic [31:0] data;
        } wbT;

        // Data memory write to a word address
        typedef struct packed {
                logic [31:0] addr;
                logic [31:0] data;
        } storeT;

endpackage

/* instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import mipsPkg::*; (
        input  logic    clk,
        input  logic    rst,
        input  instrT   instr,
        input  logic    instrValid,
        output decodedT decoded,
        output logic    decodedValid,
        output logic    illegal
);

        // Instruction fields
        logic [5:0]  opcode;
        logic [5:0]  funct;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm16;

        // Combinational decode results
        ctrlT        ctrl;
        logic        unknown;
        logic        zeroExt;
        logic [4:0]  dst;
        logic [31:0] immExt;

        assign opcode = instr.word[31:26];
        assign funct  = instr.word[5:0];
        assign rs     = instr.word[25:21];
        assign rt     = instr.word[20:16];
        assign rd     = instr.word[15:11];
        assign imm16  = instr.word[15:0];

        always_comb begin
                // Everything off by default, so an unknown code is a no-op
                ctrl    = '0;
                unknown = 1'b0;
                zeroExt = 1'b0;
                case (opcode)
                        opRType: begin
                                case (funct)
                                        functAdd: begin
                                                ctrl.regWrite = 1'b1;
                                                ctrl.regDst   = 1'b1;
                                                ctrl.aluOp    = aluAdd;
                                        end
                                        functSub: begin
                                                ctrl.regWrite = 1'b1;
                                                ctrl.regDst   = 1'b1;
                                                ctrl.aluOp    = aluSub;
                                        end
                                        functSlt: begin
                                                ctrl.regWrite = 1'b1;
                                                ctrl.regDst   = 1'b1;
                                                ctrl.aluOp    = aluSlt;
                                        end
                                        // Target comes straight from rs
                                        functJr: ctrl.jumpReg = 1'b1;
                                        default: unknown = 1'b1;
                                endcase
                        end
                        opLw: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.memToReg = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                        end
                        opSw: begin
                                ctrl.memWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                        end
                        opXori: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.aluOp    = aluXor;
                                zeroExt       = 1'b1;
                        end
                        // Difference of rs and rt decides the branch
                        opBne: begin
                                ctrl.branch = 1'b1;
                                ctrl.aluOp  = aluSub;
                        end
                        opJ: ctrl.jump = 1'b1;
                        opJal: begin
                                ctrl.jump     = 1'b1;
                                ctrl.link     = 1'b1;
                                ctrl.regWrite = 1'b1;
                        end
                        default: unknown = 1'b1;
                endcase
        end

        // Destination is rd for R-type, r31 for jal, rt otherwise
        assign dst = ctrl.regDst ? rd : (ctrl.link ? linkReg : rt);

        // xori zero-extends, lw, sw and bne sign-extend
        assign immExt = zeroExt ? {16'd0, imm16} : {{16{imm16[15]}}, imm16};

        // Payload register, qualified by decodedValid
        always_ff @(posedge clk) begin
                decoded.ctrl      <= ctrl;
                decoded.pc        <= instr.pc;
                decoded.rs        <= rs;
                decoded.rt        <= rt;
                decoded.dst       <= dst;
                decoded.imm       <= immExt;
                decoded.jumpIndex <= instr.word[25:0];
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        decodedValid <= 1'b0;
                        illegal      <= 1'b0;
                end else begin
                        decodedValid <= instrValid;
                        illegal      <= instrValid && unknown;
                end
        end

        // A store never writes the register file
        noMemAndRegWrite: assert property (@(posedge clk) disable iff (rst)
                decodedValid |-> !(decoded.ctrl.memWrite && decoded.ctrl.regWrite));

endmodule

/* operandStage.sv */
`timescale 1ns/1ps

module operandStage import mipsPkg::*; (
        input  logic    clk,
        input  logic    rst,
        input  decodedT decoded,
        input  logic    decodedValid,
        input  wbT      wb,
        input  logic    wbValid,
        output issuedT  issued,
        output logic    issuedValid
);

        // 32 general purpose registers
        logic [31:0] regFile [0:31];

        // Operand values after bypass
        logic [31:0] rsVal;
        logic [31:0] rtVal;

        // Writeback to r0 is dropped
        logic        wbWrite;

        assign wbWrite = wbValid && (wb.regNum != 5'd0);

        // Register read with the writeback of the current cycle forwarded
        function automatic logic [31:0] readReg(input logic [4:0] idx);
                logic [31:0] val;
                val = regFile[idx];
                if (idx == 5'd0) begin
                        val = 32'd0;
                end else if (wbWrite && (wb.regNum == idx)) begin
                        // Newest value, lw result included
                        val = wb.data;
                end
                return val;
        endfunction

        always_comb begin
                rsVal = readReg(decoded.rs);
                rtVal = readReg(decoded.rt);
        end

        // Register file update at the end of the execute cycle
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < 32; i++) begin
                                regFile[i] <= 32'd0;
                        end
                end else if (wbWrite) begin
                        regFile[wb.regNum] <= wb.data;
                end
        end

        // Issue register, payload carried without reset
        always_ff @(posedge clk) begin
                issued.ctrl      <= decoded.ctrl;
                issued.pc        <= decoded.pc;
                issued.dst       <= decoded.dst;
                issued.imm       <= decoded.imm;
                issued.jumpIndex <= decoded.jumpIndex;
                issued.opA       <= rsVal;
                issued.opB       <= rtVal;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        issuedValid <= 1'b0;
                end else begin
                        issuedValid <= decodedValid;
                end
        end

        // r0 must stay zero whatever the execute stage sends back
        regZeroStaysZero: assert property (@(posedge clk) disable iff (rst)
                regFile[0] == 32'd0);

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage import mipsPkg::*; #(
        parameter int memAddrBits = 8
) (
        input  logic        clk,
        input  logic        rst,
        input  issuedT      issued,
        input  logic        issuedValid,
        output wbT          wb,
        output logic        wbValid,
        output storeT       store,
        output logic        storeValid,
        output logic [31:0] redirectTarget,
        output logic        redirectValid
);

        localparam int memWords = 2 ** memAddrBits;

        // Word-addressed data memory
        logic [31:0] dataMem [0:memWords-1];

        // ALU signals
        logic [31:0] aluB;
        logic [31:0] aluResult;
        logic [memAddrBits-1:0] wordIdx;
        logic [31:0] memWord;

        // Control transfer signals
        logic [31:0] pcPlus4;
        logic [31:0] branchTarget;
        logic [31:0] jumpTarget;
        logic        branchTaken;

        // Second operand is the immediate for lw, sw and xori
        assign aluB = issued.ctrl.aluSrc ? issued.imm : issued.opB;

        always_comb begin
                case (issued.ctrl.aluOp)
                        aluAdd:  aluResult = issued.opA + aluB;
                        aluSub:  aluResult = issued.opA - aluB;
                        aluXor:  aluResult = issued.opA ^ aluB;
                        aluSlt:  aluResult = ($signed(issued.opA) < $signed(aluB)) ? 32'd1 : 32'd0;
                        default: aluResult = 32'd0;
                endcase
        end

        // Word index from the ALU byte address
        assign wordIdx = aluResult[memAddrBits+1:2];

        // Combinational read lets a following lw be bypassed
        assign memWord = dataMem[wordIdx];

        // Writeback with no pulse for r0
        always_comb begin
                wb.regNum = issued.dst;
                if (issued.ctrl.link) begin
                        wb.data = issued.pc + 32'd8;
                end else if (issued.ctrl.memToReg) begin
                        wb.data = memWord;
                end else begin
                        wb.data = aluResult;
                end
        end
        assign wbValid = issuedValid && issued.ctrl.regWrite && (issued.dst != 5'd0);

        // Store of the rt value to the computed word
        assign store.addr = 32'(wordIdx);
        assign store.data = issued.opB;
        assign storeValid = issuedValid && issued.ctrl.memWrite;

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < memWords; i++) begin
                                dataMem[i] <= 32'd0;
                        end
                end else if (storeValid) begin
                        dataMem[wordIdx] <= issued.opB;
                end
        end

        // bne taken when the difference is nonzero
        assign branchTaken = issued.ctrl.branch && (aluResult != 32'd0);

        assign pcPlus4      = issued.pc + 32'd4;
        assign branchTarget = pcPlus4 + {issued.imm[29:0], 2'b00};
        assign jumpTarget   = {pcPlus4[31:28], issued.jumpIndex, 2'b00};

        always_comb begin
                if (issued.ctrl.jumpReg) begin
                        redirectTarget = issued.opA;
                end else if (issued.ctrl.jump) begin
                        redirectTarget = jumpTarget;
                end else begin
                        redirectTarget = branchTarget;
                end
        end

        assign redirectValid = issuedValid &&
                               (branchTaken || issued.ctrl.jump || issued.ctrl.jumpReg);

        // Decoder never marks a store as a control transfer
        storeNotRedirect: assert property (@(posedge clk) disable iff (rst)
                !(storeValid && redirectValid));

endmodule

/* mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; #(
        parameter int memAddrBits = 8
) (
        input  logic        clk,
        input  logic        rst,
        input  logic        instrValid,
        input  instrT       instr,
        output logic        illegal,
        output wbT          wb,
        output logic        wbValid,
        output storeT       store,
        output logic        storeValid,
        output logic [31:0] redirectTarget,
        output logic        redirectValid
);

        // Decoder to operand stage
        decodedT decoded;
        logic    decodedValid;

        // Operand stage to execute stage
        issuedT  issued;
        logic    issuedValid;

        instrDecoder decoder (
                .clk         (clk),
                .rst         (rst),
                .instr       (instr),
                .instrValid  (instrValid),
                .decoded     (decoded),
                .decodedValid(decodedValid),
                .illegal     (illegal)
        );

        // Writeback loops back here for the register file and bypass
        operandStage operands (
                .clk         (clk),
                .rst         (rst),
                .decoded     (decoded),
                .decodedValid(decodedValid),
                .wb          (wb),
                .wbValid     (wbValid),
                .issued      (issued),
                .issuedValid (issuedValid)
        );

        executeStage #(
                .memAddrBits(memAddrBits)
        ) execute (
                .clk           (clk),
                .rst           (rst),
                .issued        (issued),
                .issuedValid   (issuedValid),
                .wb            (wb),
                .wbValid       (wbValid),
                .store         (store),
                .storeValid    (storeValid),
                .redirectTarget(redirectTarget),
                .redirectValid (redirectValid)
        );

endmodule

/* mipsCoreModel.svh */
`ifndef MIPS_CORE_MODEL_SVH
`define MIPS_CORE_MODEL_SVH

// Everything one instruction should produce on the DUT outputs
typedef struct packed {
        logic        wbValid;
        wbT          wb;
        logic        storeValid;
        storeT       store;
        logic        redirectValid;
        logic [31:0] redirect;
        logic        illegal;
} expT;

// Architectural state of the reference model
logic [31:0] modelRegs [0:31];
logic [31:0] modelMem [0:(2 ** memAddrBits)-1];

task automatic modelReset();
        for (int i = 0; i < 32; i++) begin
                modelRegs[i] = 32'd0;
        end
        for (int i = 0; i < 2 ** memAddrBits; i++) begin
                modelMem[i] = 32'd0;
        end
endtask

// r0 swallows the write and raises no pulse
task automatic modelWrite(inout expT e, input logic [4:0] dst, input logic [31:0] val);
        if (dst != 5'd0) begin
                e.wbValid     = 1'b1;
                e.wb.regNum   = dst;
                e.wb.data     = val;
                modelRegs[dst] = val;
        end
endtask

task automatic modelRedirect(inout expT e, input logic [31:0] target);
        e.redirectValid = 1'b1;
        e.redirect      = target;
endtask

// Runs one instruction in program order
task automatic modelStep(input instrT in, output expT e);
        logic [5:0]             op;
        logic [5:0]             fn;
        logic [4:0]             rs;
        logic [4:0]             rt;
        logic [4:0]             rd;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            sext;
        logic [31:0]            sum;
        logic [31:0]            pcNext;
        logic [memAddrBits-1:0] idx;
        e      = '0;
        op     = in.word[31:26];
        fn     = in.word[5:0];
        rs     = in.word[25:21];
        rt     = in.word[20:16];
        rd     = in.word[15:11];
        a      = modelRegs[rs];
        b      = modelRegs[rt];
        sext   = {{16{in.word[15]}}, in.word[15:0]};
        pcNext = in.pc + 32'd4;
        // Byte address, word index from its upper bits
        sum    = a + sext;
        idx    = sum[memAddrBits+1:2];
        case (op)
                opRType: begin
                        case (fn)
                                functAdd: modelWrite(e, rd, a + b);
                                functSub: modelWrite(e, rd, a - b);
                                functSlt: modelWrite(e, rd, {31'd0, $signed(a) < $signed(b)});
                                functJr:  modelRedirect(e, a);
                                default:  e.illegal = 1'b1;
                        endcase
                end
                opXori: modelWrite(e, rt, a ^ {16'd0, in.word[15:0]});
                opLw:   modelWrite(e, rt, modelMem[idx]);
                opSw: begin
                        e.storeValid = 1'b1;
                        e.store.addr = 32'(idx);
                        e.store.data = b;
                        modelMem[idx] = b;
                end
                opBne: begin
                        if (a != b) begin
                                modelRedirect(e, pcNext + (sext << 2));
                        end
                end
                opJ: modelRedirect(e, {pcNext[31:28], in.word[25:0], 2'b00});
                opJal: begin
                        modelRedirect(e, {pcNext[31:28], in.word[25:0], 2'b00});
                        // Return address skips the slot after the jal
                        modelWrite(e, 5'd31, in.pc + 32'd8);
                end
                default: e.illegal = 1'b1;
        endcase
endtask

`endif

/* mipsCore_tb.sv */
`timescale 1ns/1ps

module mipsCore_tb import mipsPkg::*;;

        localparam int memAddrBits = 8;

        // Test lengths in instructions, idle gaps at most maxGap per instruction
        localparam int resetCycles = 10;
        localparam int nReset      = 4;
        localparam int nArith      = 300;
        localparam int nMemory     = 200;
        localparam int nControl    = 200;
        localparam int nIllegal    = 100;
        localparam int nGaps       = 200;
        localparam int maxGap      = 3;
        // Each test also drains two cycles
        localparam int limitCycles = resetCycles + nReset + nArith + nMemory + nControl
                                     + nIllegal + nGaps * (1 + maxGap) + 6 * 2 + 20;

        logic        clk;
        logic        rst;
        logic        instrValid;
        instrT       instr;
        logic        illegal;
        wbT          wb;
        logic        wbValid;
        storeT       store;
        logic        storeValid;
        logic [31:0] redirectTarget;
        logic        redirectValid;

        logic [31:0] seed = 32'd15387;
        logic [31:0] pc;
        int          errors;
        int          checks;
        int          tests;
        int          cycleCount;

        // Expectations in flight, stage2 is due this cycle, stage1 only for illegal
        `include "mipsCoreModel.svh"
        expT stage1;
        expT stage2;

        mipsCore #(
                .memAddrBits(memAddrBits)
        ) UUT (
                .clk           (clk),
                .rst           (rst),
                .instrValid    (instrValid),
                .instr         (instr),
                .illegal       (illegal),
                .wb            (wb),
                .wbValid       (wbValid),
                .store         (store),
                .storeValid    (storeValid),
                .redirectTarget(redirectTarget),
                .redirectValid (redirectValid)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        function automatic logic [31:0] nextRand();
                seed = seed ^ (seed << 13);
                seed = seed ^ (seed >> 17);
                seed = seed ^ (seed << 5);
                return seed;
        endfunction

        // Kinds 0..10 are add sub slt xori lw sw bne j jr jal and an illegal code
        function automatic logic [31:0] buildWord(input int kind);
                logic [31:0] r;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [4:0]  rd;
                logic [15:0] imm;
                logic [15:0] memOff;
                r      = nextRand();
                // Only r0..r7 so that dependencies show up often
                rs     = {2'b00, r[2:0]};
                rt     = {2'b00, r[5:3]};
                rd     = {2'b00, r[8:6]};
                imm    = r[31:16];
                // Base r0 and sixteen words, so lw often hits an earlier sw
                memOff = {10'd0, r[12:9], 2'b00};
                case (kind)
                        0: return {opRType, rs, rt, rd, 5'd0, functAdd};
                        1: return {opRType, rs, rt, rd, 5'd0, functSub};
                        2: return {opRType, rs, rt, rd, 5'd0, functSlt};
                        3: return {opXori, rs, rt, imm};
                        4: return {opLw, 5'd0, rt, memOff};
                        5: return {opSw, 5'd0, rt, memOff};
                        6: return {opBne, rs, rt, imm};
                        7: return {opJ, r[25:0]};
                        8: return {opRType, rs, 15'd0, functJr};
                        9: return {opJal, r[25:0]};
                        default: begin
                                case (r[14:13])
                                        2'd0: return {6'h3f, r[25:0]};
                                        2'd1: return {6'h08, r[25:0]};
                                        default: return {opRType, rs, rt, rd, 5'd0, 6'h25};
                                endcase
                        end
                endcase
        endfunction

        task automatic reportProblem(input string test, input string what);
                $display("[FAIL] %s: %s", test, what);
                errors++;
        endtask

        task automatic compareWb(input string test, input wbT exp, input wbT act);
                checks++;
                if (act !== exp) begin
                        $display("[FAIL] %s: wb expected r%0d=%08h, actual r%0d=%08h",
                                 test, exp.regNum, exp.data, act.regNum, act.data);
                        errors++;
                end
        endtask

        task automatic compareStore(input string test, input storeT exp, input storeT act);
                checks++;
                if (act !== exp) begin
                        $display("[FAIL] %s: store expected [%0d]=%08h, actual [%0d]=%08h",
                                 test, exp.addr, exp.data, act.addr, act.data);
                        errors++;
                end
        endtask

        task automatic compareRedirect(input string test, input logic [31:0] exp,
                                       input logic [31:0] act);
                checks++;
                if (act !== exp) begin
                        $display("[FAIL] %s: redirect expected %08h, actual %08h",
                                 test, exp, act);
                        errors++;
                end
        endtask

        task automatic compareIllegal(input string test, input logic exp, input logic act);
                checks++;
                if (act !== exp) begin
                        $display("[FAIL] %s: illegal expected %b, actual %b", test, exp, act);
                        errors++;
                end
        endtask

        // Pulse presence first, then the payload when one was due
        task automatic checkOutputs(input string test, input expT e, input logic expIllegal);
                if (wbValid !== e.wbValid) begin
                        reportProblem(test, e.wbValid ? "wb pulse missing"
                                                      : "wb pulse with no register write due");
                end else if (e.wbValid) begin
                        compareWb(test, e.wb, wb);
                end
                if (storeValid !== e.storeValid) begin
                        reportProblem(test, e.storeValid ? "store pulse missing"
                                                         : "store pulse with no sw due");
                end else if (e.storeValid) begin
                        compareStore(test, e.store, store);
                end
                if (redirectValid !== e.redirectValid) begin
                        reportProblem(test, e.redirectValid ? "redirect pulse missing"
                                                            : "redirect pulse with no transfer due");
                end else if (e.redirectValid) begin
                        compareRedirect(test, e.redirect, redirectTarget);
                end
                compareIllegal(test, expIllegal, illegal);
        endtask

        // One clock: check what is due, then drive the next input
        task automatic stepCycle(input string test, input logic send, input instrT in);
                expT e;
                @(negedge clk);
                checkOutputs(test, stage2, stage1.illegal);
                e = '0;
                if (send) begin
                        modelStep(in, e);
                        instr = in;
                end else begin
                        // Junk on the bus while idle must stay invisible
                        instr.pc   = pc;
                        instr.word = nextRand();
                end
                instrValid = send;
                stage2     = stage1;
                stage1     = e;
        endtask

        task automatic runTest(input string name, input int count, input int lo, input int hi,
                               input int gapMax);
                int    startErrors;
                int    gap;
                instrT in;
                startErrors = errors;
                for (int n = 0; n < count; n++) begin
                        if (gapMax > 0) begin
                                gap = int'(nextRand() % 32'(gapMax + 1));
                                repeat (gap) stepCycle(name, 1'b0, '0);
                        end
                        in.pc   = pc;
                        in.word = buildWord(lo + int'(nextRand() % 32'(hi - lo + 1)));
                        pc      = pc + 32'd4;
                        stepCycle(name, 1'b1, in);
                end
                // Let the last two instructions reach the outputs
                repeat (2) stepCycle(name, 1'b0, '0);
                tests++;
                $display("%-8s %0d instructions, %0d errors", name, count, errors - startErrors);
        endtask

        initial begin : watchdog
                cycleCount = 0;
                while (cycleCount < limitCycles) begin
                        @(posedge clk);
                        cycleCount++;
                end
                $display("Timeout: the tests did not end within %0d cycles", limitCycles);
                $display("Finished with errors");
                $finish;
        end

        initial begin
                rst        = 1'b1;
                instrValid = 1'b0;
                instr      = '0;
                pc         = 32'h0040_0000;
                errors     = 0;
                checks     = 0;
                tests      = 0;
                stage1     = '0;
                stage2     = '0;
                modelReset();
                repeat (resetCycles) begin
                        @(negedge clk);
                        if (wbValid === 1'b1 || storeValid === 1'b1 ||
                            redirectValid === 1'b1 || illegal === 1'b1) begin
                                reportProblem("reset", "output pulse while reset is held");
                        end
                end
                rst = 1'b0;
                // Adds right after reset read the cleared register file
                runTest("reset", nReset, 0, 0, 0);
                runTest("arith", nArith, 0, 3, 0);
                runTest("memory", nMemory, 3, 5, 0);
                runTest("control", nControl, 3, 9, 0);
                runTest("illegal", nIllegal, 9, 10, 0);
                runTest("gaps", nGaps, 0, 10, maxGap);
                $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
                if (errors == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

/* mipsCore.f */
+incdir+.
mipsPkg.sv
instrDecoder.sv
operandStage.sv
executeStage.sv
mipsCore.sv
mipsCore_tb.sv

/* Bender.yml */
package:
  name: mipsCore

sources:
  - mipsPkg.sv
  - instrDecoder.sv
  - operandStage.sv
  - executeStage.sv
  - mipsCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - mipsCore_tb.sv
